// File: rtl/fetch_pkg.sv
package fetch_pkg;

    // instruction word and pc width
    localparam int XLEN = 32;

    // fetch fault code carried with each slot
    localparam int FAULT_W = 2;

    typedef enum logic [FAULT_W-1:0] {
        FAULT_NONE     = 2'd0,
        FAULT_MISALIGN = 2'd1,
        FAULT_PAGE     = 2'd2,
        FAULT_ACCESS   = 2'd3
    } fault_e;

    // fifo word layout, lowest field first
    localparam int PC_LSB = 0;
    localparam int INST_LSB = PC_LSB + XLEN;
    localparam int BRANCH_BIT = INST_LSB + XLEN;
    localparam int TAKEN_BIT = BRANCH_BIT + 1;
    localparam int TARGET_LSB = TAKEN_BIT + 1;
    localparam int FAULT_LSB = TARGET_LSB + XLEN;
    localparam int VALID_BIT = FAULT_LSB + FAULT_W;

    // 101 bits in total
    localparam int ENTRY_W = VALID_BIT + 1;

endpackage

// File: rtl/inst_fifo.sv
`timescale 1ns/1ps

module inst_fifo #(
    parameter int DEPTH = 32,
    parameter int WIDTH = 101
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush_i,
    input  logic             push_i,
    input  logic [WIDTH-1:0] push_data_i,
    input  logic             pop_i,
    output logic [WIDTH-1:0] pop_data_o,
    output logic             full_o,
    output logic             empty_o
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // pointers wrap on their own since depth is a power of two
    generate
        if ((DEPTH & (DEPTH - 1)) != 0) begin : gen_depth_check
            $error("inst_fifo: DEPTH must be a power of two");
        end
    endgenerate

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [AW:0]      count;
    logic             do_push;
    logic             do_pop;

    assign full_o  = (count == DEPTH[AW:0]);
    assign empty_o = (count == '0);

    // first word falls through
    assign pop_data_o = mem[rd_ptr];

    assign do_pop  = pop_i && !empty_o;
    assign do_push = push_i && (!full_o || do_pop);

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // push controller must hold off a full lane
    a_no_push_full: assert property (
        @(posedge clk) disable iff (rst || flush_i)
        (push_i && full_o) |-> pop_i
    ) else $error("inst_fifo: push while full");

    // combiner only pops a lane that shows a head
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (rst || flush_i)
        !(pop_i && empty_o)
    ) else $error("inst_fifo: pop while empty");

endmodule

// File: rtl/fetch_push_ctrl.sv
`timescale 1ns/1ps

module fetch_push_ctrl
    import fetch_pkg::*;
(
    input  logic                      stall_i,
    input  logic [1:0]                fetch_en_i,
    input  logic [1:0][XLEN-1:0]      inst_i,
    input  logic [1:0][XLEN-1:0]      pc_i,
    input  fault_e [1:0]              fault_i,
    input  logic [1:0]                is_branch_i,
    input  logic [1:0]                pred_taken_i,
    input  logic [XLEN-1:0]           pred_target_i,
    input  logic [1:0]                lane_full_i,
    output logic [1:0]                push_o,
    output logic [1:0][ENTRY_W-1:0]   push_data_o,
    output logic                      buffer_full_o
);

    logic       accept;
    logic       squash_1;

    // one full lane refuses the whole pair
    assign buffer_full_o = lane_full_i[0] | lane_full_i[1];
    assign accept        = !stall_i && !buffer_full_o;

    // taken branch in slot 0 ends the fetch group
    assign squash_1 = fetch_en_i[0] && is_branch_i[0] && pred_taken_i[0];

    assign push_o[0] = accept && fetch_en_i[0];
    assign push_o[1] = accept && fetch_en_i[1];

    always_comb begin
        push_data_o = '0;
        for (int i = 0; i < 2; i++) begin
            push_data_o[i][PC_LSB +: XLEN]       = pc_i[i];
            push_data_o[i][INST_LSB +: XLEN]     = inst_i[i];
            push_data_o[i][BRANCH_BIT]           = is_branch_i[i];
            push_data_o[i][TAKEN_BIT]            = pred_taken_i[i];
            push_data_o[i][TARGET_LSB +: XLEN]   = pred_target_i;
            push_data_o[i][FAULT_LSB +: FAULT_W] = fault_i[i];
            // only slot 1 can be written as a bubble
            push_data_o[i][VALID_BIT]            = (i == 0) || !squash_1;
        end
    end

    // fetch never offers slot 1 on its own, so lane 1 never runs ahead of lane 0
    always_comb begin
        a_slot1_after_slot0: assert final (!push_o[1] || push_o[0])
            else $error("fetch_push_ctrl: slot 1 pushed without slot 0");
    end

endmodule

// File: rtl/issue_combiner.sv
`timescale 1ns/1ps

module issue_combiner
    import fetch_pkg::*;
(
    input  logic                      pause_i,
    input  logic [1:0]                send_en_i,
    input  logic [1:0][ENTRY_W-1:0]   lane_data_i,
    input  logic [1:0]                lane_empty_i,
    output logic [1:0]                lane_pop_o,
    output logic [1:0]                issue_valid_o,
    output logic [1:0][XLEN-1:0]      issue_inst_o,
    output logic [1:0][XLEN-1:0]      issue_pc_o,
    output fault_e [1:0]              issue_fault_o,
    output logic [1:0]                issue_is_branch_o,
    output logic [1:0]                issue_pred_taken_o,
    output logic [1:0][XLEN-1:0]      issue_pred_target_o
);

    logic [1:0] head_real;
    logic [1:0] head_bubble;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            head_real[i]   = !lane_empty_i[i] && lane_data_i[i][VALID_BIT];
            head_bubble[i] = !lane_empty_i[i] && !lane_data_i[i][VALID_BIT];
        end
    end

    assign issue_valid_o = head_real & {2{!pause_i}};

    // taken by the decoder, or a squashed slot dropped on its own
    assign lane_pop_o = (issue_valid_o & send_en_i) | (head_bubble & {2{!pause_i}});

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (issue_valid_o[i]) begin
                issue_pc_o[i]          = lane_data_i[i][PC_LSB +: XLEN];
                issue_inst_o[i]        = lane_data_i[i][INST_LSB +: XLEN];
                issue_is_branch_o[i]   = lane_data_i[i][BRANCH_BIT];
                issue_pred_taken_o[i]  = lane_data_i[i][TAKEN_BIT];
                issue_pred_target_o[i] = lane_data_i[i][TARGET_LSB +: XLEN];
                issue_fault_o[i]       = fault_e'(lane_data_i[i][FAULT_LSB +: FAULT_W]);
            end else begin
                issue_pc_o[i]          = '0;
                issue_inst_o[i]        = '0;
                issue_is_branch_o[i]   = 1'b0;
                issue_pred_taken_o[i]  = 1'b0;
                issue_pred_target_o[i] = '0;
                issue_fault_o[i]       = FAULT_NONE;
            end
        end
    end

endmodule

// File: rtl/inst_buffer_top.sv
`timescale 1ns/1ps

module inst_buffer_top
    import fetch_pkg::*;
#(
    parameter int DEPTH = 32
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush_i,
    input  logic                      stall_i,
    input  logic                      pause_i,
    input  logic [1:0]                fetch_en_i,
    input  logic [1:0][XLEN-1:0]      inst_i,
    input  logic [1:0][XLEN-1:0]      pc_i,
    input  fault_e [1:0]              fault_i,
    input  logic [1:0]                is_branch_i,
    input  logic [1:0]                pred_taken_i,
    input  logic [XLEN-1:0]           pred_target_i,
    input  logic [1:0]                send_en_i,
    output logic                      buffer_full_o,
    output logic [1:0]                issue_valid_o,
    output logic [1:0][XLEN-1:0]      issue_inst_o,
    output logic [1:0][XLEN-1:0]      issue_pc_o,
    output fault_e [1:0]              issue_fault_o,
    output logic [1:0]                issue_is_branch_o,
    output logic [1:0]                issue_pred_taken_o,
    output logic [1:0][XLEN-1:0]      issue_pred_target_o
);

    logic [1:0]              lane_push;
    logic [1:0][ENTRY_W-1:0] lane_push_data;
    logic [1:0]              lane_pop;
    logic [1:0][ENTRY_W-1:0] lane_head;
    logic [1:0]              lane_full;
    logic [1:0]              lane_empty;

    fetch_push_ctrl fetch_push_ctrl_inst (
        .stall_i       (stall_i),
        .fetch_en_i    (fetch_en_i),
        .inst_i        (inst_i),
        .pc_i          (pc_i),
        .fault_i       (fault_i),
        .is_branch_i   (is_branch_i),
        .pred_taken_i  (pred_taken_i),
        .pred_target_i (pred_target_i),
        .lane_full_i   (lane_full),
        .push_o        (lane_push),
        .push_data_o   (lane_push_data),
        .buffer_full_o (buffer_full_o)
    );

    // one lane per issue slot
    for (genvar i = 0; i < 2; i++) begin : gen_lane
        inst_fifo #(
            .DEPTH (DEPTH),
            .WIDTH (ENTRY_W)
        ) lane_inst (
            .clk         (clk),
            .rst         (rst),
            .flush_i     (flush_i),
            .push_i      (lane_push[i]),
            .push_data_i (lane_push_data[i]),
            .pop_i       (lane_pop[i]),
            .pop_data_o  (lane_head[i]),
            .full_o      (lane_full[i]),
            .empty_o     (lane_empty[i])
        );
    end

    issue_combiner issue_combiner_inst (
        .pause_i             (pause_i),
        .send_en_i           (send_en_i),
        .lane_data_i         (lane_head),
        .lane_empty_i        (lane_empty),
        .lane_pop_o          (lane_pop),
        .issue_valid_o       (issue_valid_o),
        .issue_inst_o        (issue_inst_o),
        .issue_pc_o          (issue_pc_o),
        .issue_fault_o       (issue_fault_o),
        .issue_is_branch_o   (issue_is_branch_o),
        .issue_pred_taken_o  (issue_pred_taken_o),
        .issue_pred_target_o (issue_pred_target_o)
    );

endmodule

// File: sim/tb_vectors.svh
// columns: fetch_en, pc of slot 0 (slot 1 is pc + 4), inst slot 0, inst slot 1,
// {fault1, fault0}, is_branch, pred_taken, target, stall, pause, send_en, flush, phase
task automatic build_table();
    add_row(2'b11, 'h1000, 'h013, 'h093, 'h0, 2'b00, 2'b00, 'h0000, 0, 0, 2'b11, 0, "pair");
    add_row(2'b11, 'h1008, 'h113, 'h193, 'h6, 2'b10, 2'b00, 'h2000, 0, 0, 2'b11, 0, "pair");
    add_row(2'b11, 'h1010, 'h213, 'h293, 'hc, 2'b11, 2'b10, 'h2400, 0, 0, 2'b11, 0, "pair");
    // taken branch in slot 0
    add_row(2'b11, 'h1018, 'h063, 'h393, 'h0, 2'b01, 2'b01, 'h3000, 0, 0, 2'b11, 0, "squash");
    add_row(2'b11, 'h3000, 'h413, 'h493, 'h0, 2'b00, 2'b00, 'h0000, 0, 0, 2'b11, 0, "squash");
    add_row(2'b00, 'h0000, 'h000, 'h000, 'h0, 2'b00, 2'b00, 'h0000, 0, 0, 2'b11, 0, "squash");
    // four pairs fill both lanes
    add_row(2'b11, 'h4000, 'h513, 'h593, 'h0, 2'b00, 2'b00, 'h0000, 0, 0, 2'b00, 0, "full");
    add_row(2'b11, 'h4008, 'h613, 'h693, 'h1, 2'b00, 2'b00, 'h0000, 0, 0, 2'b00, 0, "full");
    add_row(2'b11, 'h4010, 'h713, 'h793, 'h0, 2'b00, 2'b00, 'h0000, 0, 0, 2'b00, 0, "full");
    add_row(2'b11, 'h4018, 'h813, 'h893, 'h8, 2'b00, 2'b00, 'h0000, 0, 0, 2'b00, 0, "full");
    add_row(2'b11, 'h4020, 'h913, 'h993, 'h0, 2'b00, 2'b00, 'h0000, 0, 0, 2'b00, 0, "full");
    add_row(2'b11, 'h4020, 'h913, 'h993, 'h0, 2'b00, 2'b00, 'h0000, 0, 0, 2'b11, 0, "full");
    add_row(2'b11, 'h4020, 'h913, 'h993, 'h0, 2'b00, 2'b00, 'h0000, 0, 0, 2'b11, 0, "full");
    add_row(2'b11, 'h5000, 'ha13, 'ha93, 'h0, 2'b00, 2'b00, 'h0000, 1, 0, 2'b11, 0, "stall");
    add_row(2'b11, 'h5000, 'ha13, 'ha93, 'h0, 2'b00, 2'b00, 'h0000, 1, 0, 2'b11, 0, "stall");
    add_row(2'b11, 'h5000, 'ha13, 'ha93, 'h0, 2'b00, 2'b00, 'h0000, 0, 0, 2'b11, 0, "stall");
    add_row(2'b00, 'h0000, 'h000, 'h000, 'h0, 2'b00, 2'b00, 'h0000, 0, 0, 2'b11, 0, "stall");
    add_row(2'b11, 'h6000, 'hb13, 'hb93, 'h9, 2'b00, 2'b00, 'h0000, 0, 0, 2'b00, 0, "pause");
    add_row(2'b11, 'h6008, 'hc13, 'hc93, 'h0, 2'b01, 2'b00, 'h7700, 0, 1, 2'b11, 0, "pause");
    add_row(2'b00, 'h0000, 'h000, 'h000, 'h0, 2'b00, 2'b00, 'h0000, 0, 1, 2'b11, 0, "pause");
    add_row(2'b00, 'h0000, 'h000, 'h000, 'h0, 2'b00, 2'b00, 'h0000, 0, 0, 2'b01, 0, "pause");
    add_row(2'b00, 'h0000, 'h000, 'h000, 'h0, 2'b00, 2'b00, 'h0000, 0, 0, 2'b10, 0, "pause");
    add_row(2'b00, 'h0000, 'h000, 'h000, 'h0, 2'b00, 2'b00, 'h0000, 0, 0, 2'b11, 0, "pause");
    add_row(2'b11, 'h7000, 'hd13, 'hd93, 'h0, 2'b00, 2'b00, 'h0000, 0, 0, 2'b00, 0, "flush");
    add_row(2'b11, 'h7008, 'he13, 'he93, 'h0, 2'b00, 2'b00, 'h0000, 0, 0, 2'b00, 0, "flush");
    add_row(2'b11, 'h7010, 'hf13, 'hf93, 'h0, 2'b00, 2'b00, 'h0000, 0, 0, 2'b11, 1, "flush");
    add_row(2'b00, 'h0000, 'h000, 'h000, 'h0, 2'b00, 2'b00, 'h0000, 0, 0, 2'b11, 0, "flush");
    add_row(2'b11, 'h8000, 'h1013, 'h1093, 'h2, 2'b00, 2'b00, 'h0000, 0, 0, 2'b11, 0, "flush");
    add_row(2'b00, 'h0000, 'h000, 'h000, 'h0, 2'b00, 2'b00, 'h0000, 0, 0, 2'b11, 0, "flush");
    add_row(2'b00, 'h0000, 'h000, 'h000, 'h0, 2'b00, 2'b00, 'h0000, 0, 0, 2'b00, 0, "flush");
endtask

// File: sim/tb_inst_buffer.sv
`timescale 1ns/1ps

module tb_inst_buffer;
    import fetch_pkg::*;

    localparam int DEPTH = 4;
    localparam int RESET_CYCLES = 5;

    typedef struct packed {
        logic [1:0]      en;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst0;
        logic [XLEN-1:0] inst1;
        logic [3:0]      flt;
        logic [1:0]      br;
        logic [1:0]      tk;
        logic [XLEN-1:0] target;
        logic            stall;
        logic            pause;
        logic [1:0]      send;
        logic            flush;
    } row_t;

    // one lane entry as the reference model holds it
    typedef struct packed {
        logic            valid;
        fault_e          fault;
        logic [XLEN-1:0] target;
        logic            tk;
        logic            br;
        logic [XLEN-1:0] inst;
        logic [XLEN-1:0] pc;
    } entry_t;

    logic                 clk;
    logic                 rst;
    logic                 flush;
    logic                 stall;
    logic                 pause;
    logic [1:0]           fetch_en;
    logic [1:0][XLEN-1:0] inst;
    logic [1:0][XLEN-1:0] pc;
    fault_e [1:0]         fault;
    logic [1:0]           is_branch;
    logic [1:0]           pred_taken;
    logic [XLEN-1:0]      pred_target;
    logic [1:0]           send_en;
    logic                 buffer_full_o;
    logic [1:0]           issue_valid_o;
    logic [1:0][XLEN-1:0] issue_inst_o;
    logic [1:0][XLEN-1:0] issue_pc_o;
    fault_e [1:0]         issue_fault_o;
    logic [1:0]           issue_is_branch_o;
    logic [1:0]           issue_pred_taken_o;
    logic [1:0][XLEN-1:0] issue_pred_target_o;

    row_t   rows[$];
    string  tags[$];
    entry_t lane_q[2][$];
    int     mismatches = 0;
    int     failures = 0;
    int     cycles = 0;
    int     timeout_limit = 0;

    inst_buffer_top #(
        .DEPTH (DEPTH)
    ) inst_buffer_top_inst (
        .clk                 (clk),
        .rst                 (rst),
        .flush_i             (flush),
        .stall_i             (stall),
        .pause_i             (pause),
        .fetch_en_i          (fetch_en),
        .inst_i              (inst),
        .pc_i                (pc),
        .fault_i             (fault),
        .is_branch_i         (is_branch),
        .pred_taken_i        (pred_taken),
        .pred_target_i       (pred_target),
        .send_en_i           (send_en),
        .buffer_full_o       (buffer_full_o),
        .issue_valid_o       (issue_valid_o),
        .issue_inst_o        (issue_inst_o),
        .issue_pc_o          (issue_pc_o),
        .issue_fault_o       (issue_fault_o),
        .issue_is_branch_o   (issue_is_branch_o),
        .issue_pred_taken_o  (issue_pred_taken_o),
        .issue_pred_target_o (issue_pred_target_o)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (timeout_limit > 0 && cycles > timeout_limit) begin
            $display("Timeout: run did not end within %0d cycles", timeout_limit);
            $display("Finished with errors");
            $finish;
        end
    end

    function automatic void add_row(
        int en, logic [XLEN-1:0] row_pc, logic [XLEN-1:0] inst0, logic [XLEN-1:0] inst1,
        int flt, int br, int tk, logic [XLEN-1:0] target,
        int stl, int pau, int send, int fl, string tag
    );
        row_t r;
        r.en     = en[1:0];
        r.pc     = row_pc;
        r.inst0  = inst0;
        r.inst1  = inst1;
        r.flt    = flt[3:0];
        r.br     = br[1:0];
        r.tk     = tk[1:0];
        r.target = target;
        r.stall  = (stl != 0);
        r.pause  = (pau != 0);
        r.send   = send[1:0];
        r.flush  = (fl != 0);
        rows.push_back(r);
        tags.push_back(tag);
    endfunction

    `include "tb_vectors.svh"

    task automatic check_word(string name, logic [XLEN-1:0] act, logic [XLEN-1:0] exp);
        if (act !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, act, exp);
        end
    endtask

    task automatic check_fault(string name, fault_e act, fault_e exp);
        if (act !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s is %s, expected %s", $time, name, act.name(),
                     exp.name());
        end
    endtask

    task automatic check_bit(string name, logic act, logic exp);
        if (act !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s is %b, expected %b", $time, name, act, exp);
        end
    endtask

    task automatic apply_row(row_t r);
        fetch_en    = r.en;
        pc[0]       = r.pc;
        pc[1]       = r.pc + 32'd4;
        inst[0]     = r.inst0;
        inst[1]     = r.inst1;
        fault[0]    = fault_e'(r.flt[1:0]);
        fault[1]    = fault_e'(r.flt[3:2]);
        is_branch   = r.br;
        pred_taken  = r.tk;
        pred_target = r.target;
        stall       = r.stall;
        pause       = r.pause;
        send_en     = r.send;
        flush       = r.flush;
    endtask

    // compare the settled outputs, then step the model across the coming edge
    task automatic check_and_model(row_t r, string tag);
        entry_t     head;
        entry_t     e;
        logic       full_exp;
        logic       valid_exp;
        logic       accept;
        logic [1:0] pops;
        string      slot;
        pops = 2'b00;
        full_exp = (lane_q[0].size() >= DEPTH) || (lane_q[1].size() >= DEPTH);
        check_bit({tag, " buffer_full_o"}, buffer_full_o, full_exp);
        for (int i = 0; i < 2; i++) begin
            slot = $sformatf("%s slot %0d", tag, i);
            if (lane_q[i].size() == 0) begin
                if (issue_valid_o[i] !== 1'b0) begin
                    failures++;
                    $display("%0t: %s issued an entry while the model lane is empty",
                             $time, slot);
                end
            end else begin
                head = lane_q[i][0];
                valid_exp = head.valid && !r.pause;
                check_bit({slot, " issue_valid_o"}, issue_valid_o[i], valid_exp);
                if (valid_exp) begin
                    check_word({slot, " issue_pc_o"}, issue_pc_o[i], head.pc);
                    check_word({slot, " issue_inst_o"}, issue_inst_o[i], head.inst);
                    check_word({slot, " issue_pred_target_o"}, issue_pred_target_o[i],
                               head.target);
                    check_fault({slot, " issue_fault_o"}, issue_fault_o[i], head.fault);
                    check_bit({slot, " issue_is_branch_o"}, issue_is_branch_o[i], head.br);
                    check_bit({slot, " issue_pred_taken_o"}, issue_pred_taken_o[i], head.tk);
                end
                // bubbles drop on their own, real entries need send_en
                pops[i] = !r.pause && (!head.valid || r.send[i]);
            end
        end
        if (r.flush) begin
            lane_q[0].delete();
            lane_q[1].delete();
        end else begin
            accept = !r.stall && !full_exp;
            for (int i = 0; i < 2; i++) begin
                if (pops[i]) begin
                    void'(lane_q[i].pop_front());
                end
                if (accept && r.en[i]) begin
                    e.pc     = r.pc + 32'(4 * i);
                    e.inst   = (i == 0) ? r.inst0 : r.inst1;
                    e.br     = r.br[i];
                    e.tk     = r.tk[i];
                    e.target = r.target;
                    e.fault  = fault_e'(r.flt[2*i +: 2]);
                    e.valid  = (i == 0) || !(r.en[0] && r.br[0] && r.tk[0]);
                    if (lane_q[i].size() >= DEPTH) begin
                        failures++;
                        $display("%0t: %s push into lane %0d overflows the model", $time,
                                 tag, i);
                    end else begin
                        lane_q[i].push_back(e);
                    end
                end
            end
        end
    endtask

    initial begin
        apply_row('0);
        rst = 1'b1;
        build_table();
        timeout_limit = rows.size() + RESET_CYCLES + 20;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        check_bit("reset buffer_full_o", buffer_full_o, 1'b0);
        check_bit("reset issue_valid_o[0]", issue_valid_o[0], 1'b0);
        check_bit("reset issue_valid_o[1]", issue_valid_o[1], 1'b0);
        for (int n = 0; n < rows.size(); n++) begin
            @(posedge clk);
            #2;
            apply_row(rows[n]);
            @(negedge clk);
            check_and_model(rows[n], tags[n]);
        end
        @(posedge clk);
        #2;
        apply_row('0);
        for (int i = 0; i < 2; i++) begin
            if (lane_q[i].size() != 0) begin
                failures++;
                $display("Lane %0d still holds %0d entries that never issued", i,
                         lane_q[i].size());
            end
        end
        $display("Error counts: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+sim
rtl/fetch_pkg.sv
rtl/inst_fifo.sv
rtl/fetch_push_ctrl.sv
rtl/issue_combiner.sv
rtl/inst_buffer_top.sv
sim/tb_inst_buffer.sv
